/* tb.f */
+incdir+common
common/types_amba_pkg.sv
rtl/axi_defslv.sv
rtl/axi_sram_slave.sv
xbar/axi_bus_router.sv
rtl/axi_subsys_top.sv
test/axi_subsys_asserts.sv
test/tb_axi_subsys.sv

/* Makefile */
TOP := tb_axi_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST RESULT: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* test/tb_axi_subsys.sv */
`timescale 1ns/100ps
`include "amba_consts.svh"

module tb_axi_subsys;

    import types_amba_pkg::*;

    localparam int timeout_cycles = 100;

    logic i_clk;
    logic i_nrst;
    axi4_slave_in_type xmsti;
    axi4_slave_out_type xmsto;
    logic [31:0] lfsr;
    logic [31:0] model_mem [0:1][0:`SRAM_WORDS-1];
    logic [3:0] model_vld [0:1][0:`SRAM_WORDS-1];  // bytes written so far
    int error_count;
    int test_count;
    int fail_count;
    bit timed_out;
    bit stall_en;

    axi_subsys_top UUT (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xmsti(xmsti),
        .o_xmsto(xmsto)
    );

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic ready_draw();
        return stall_en ? (rand_bits(2) != 0) : 1'b1;  // stalls about one cycle in four
    endfunction

    function automatic logic [31:0] region_addr(input int region, input int off);
        logic [31:0] base;
        case (region)
            0: base = `SRAM0_BASE;
            1: base = `SRAM1_BASE;
            default: base = 32'h0000_2000;  // first unmapped window
        endcase
        return base + (off << 2);
    endfunction

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic count_tick(inout int t, input string what);
        t++;
        if (t > timeout_cycles && !timed_out) begin
            timed_out = 1'b1;
            error_count++;
            $display("timeout: no %s within %0d cycles at %0t ns", what, timeout_cycles, $time);
        end
    endtask

    task automatic send_addr(input bit is_wr, input logic [31:0] addr, input int len);
        int t;
        t = 0;
        @(negedge i_clk);
        if (is_wr) begin
            xmsti.aw_valid = 1'b1;
            xmsti.aw_bits = '{addr: addr, len: len[7:0]};
        end else begin
            xmsti.ar_valid = 1'b1;
            xmsti.ar_bits = '{addr: addr, len: len[7:0]};
        end
        #10;
        while (!(is_wr ? xmsto.aw_ready : xmsto.ar_ready) && !timed_out) begin
            @(negedge i_clk);
            #10;
            count_tick(t, "address ready");
        end
    endtask

    task automatic write_burst(input int region, input int off, input int len);
        int t;
        int w;
        logic [31:0] data;
        logic [3:0] strb;
        axi_resp_type exp_resp;
        exp_resp = (region == 2) ? AXI_RESP_DECERR : AXI_RESP_OKAY;
        send_addr(1'b1, region_addr(region, off), len);
        for (int beat = 0; beat <= len && !timed_out; beat++) begin
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            t = 0;
            @(negedge i_clk);
            xmsti.aw_valid = 1'b0;
            xmsti.w_valid = 1'b1;
            xmsti.w_data = data;
            xmsti.w_strb = strb;
            xmsti.w_last = (beat == len);
            #10;
            while (!xmsto.w_ready && !timed_out) begin
                @(negedge i_clk);
                #10;
                count_tick(t, "w_ready");
            end
            w = (off + beat) % `SRAM_WORDS;
            for (int b = 0; b < 4 && region < 2; b++) begin
                if (strb[b]) begin
                    model_mem[region][w][8*b +: 8] = data[8*b +: 8];
                    model_vld[region][w][b] = 1'b1;
                end
            end
        end
        if (timed_out) begin
            return;
        end
        t = 0;
        @(negedge i_clk);
        xmsti.w_valid = 1'b0;
        xmsti.w_last = 1'b0;
        xmsti.b_ready = ready_draw();
        #10;
        if (!xmsto.b_valid) begin
            report_mismatch("b_valid not one cycle after the last W beat");
        end
        while (!(xmsto.b_valid && xmsti.b_ready) && !timed_out) begin
            @(negedge i_clk);
            xmsti.b_ready = ready_draw();
            #10;
            count_tick(t, "write response");
        end
        if (!timed_out && xmsto.b_resp !== exp_resp) begin
            report_mismatch($sformatf("b_resp %0d, expected %0d", xmsto.b_resp, exp_resp));
        end
        @(negedge i_clk);
        xmsti.b_ready = 1'b0;
        #10;
        if (!timed_out && xmsto.b_valid) begin
            report_mismatch("second b_valid after the write response");
        end
    endtask

    task automatic read_burst(input int region, input int off, input int len);
        int t;
        int w;
        int beat;
        logic [31:0] mask;
        logic [31:0] exp_data;
        axi_resp_type exp_resp;
        exp_resp = (region == 2) ? AXI_RESP_DECERR : AXI_RESP_OKAY;
        send_addr(1'b0, region_addr(region, off), len);
        if (timed_out) begin
            return;
        end
        t = 0;
        beat = 0;
        @(negedge i_clk);
        xmsti.ar_valid = 1'b0;
        xmsti.r_ready = ready_draw();
        #10;
        if (!xmsto.r_valid) begin
            report_mismatch("r_valid not one cycle after the AR handshake");
        end
        while (beat <= len && !timed_out) begin
            if (xmsto.r_valid && xmsti.r_ready) begin
                w = (off + beat) % `SRAM_WORDS;
                mask = '1;
                exp_data = '1;  // unmapped reads return all ones
                if (region < 2) begin
                    mask = {{8{model_vld[region][w][3]}}, {8{model_vld[region][w][2]}},
                            {8{model_vld[region][w][1]}}, {8{model_vld[region][w][0]}}};
                    exp_data = model_mem[region][w] & mask;
                end
                if ((xmsto.r_data & mask) !== exp_data) begin
                    report_mismatch($sformatf("region %0d word %0d data %h, expected %h",
                                              region, w, xmsto.r_data & mask, exp_data));
                end
                if (xmsto.r_resp !== exp_resp || xmsto.r_last !== (beat == len)) begin
                    report_mismatch($sformatf("beat %0d of %0d has r_resp %0d r_last %b",
                                              beat, len + 1, xmsto.r_resp, xmsto.r_last));
                end
                beat++;
                t = 0;
            end
            @(negedge i_clk);
            xmsti.r_ready = (beat <= len) ? ready_draw() : 1'b0;
            #10;
            count_tick(t, "read data");
        end
        if (!timed_out && xmsto.r_valid) begin
            report_mismatch("r_valid still high after the r_last beat");
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errs_before);
        end
    endtask

    initial begin : main_proc
        int errs;
        int off;
        int len;
        int region;
        int last_off;
        int last_len;

        i_clk = 1'b0;
        i_nrst = 1'b0;
        xmsti = '0;
        lfsr = 32'hc8ca;
        error_count = 0;
        test_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        stall_en = 1'b0;
        last_off = 0;
        last_len = 0;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < `SRAM_WORDS; i++) begin
                model_vld[r][i] = '0;
            end
        end
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;
        #10;

        errs = error_count;
        if (xmsto.b_valid || xmsto.r_valid || !xmsto.aw_ready || !xmsto.ar_ready) begin
            report_mismatch($sformatf("after reset b_valid %b r_valid %b aw_ready %b ar_ready %b",
                                      xmsto.b_valid, xmsto.r_valid, xmsto.aw_ready,
                                      xmsto.ar_ready));
        end
        finish_test("reset state", errs);

        // same offset in both regions, so aliasing shows up as wrong data
        errs = error_count;
        for (int i = 0; i < 12 && !timed_out; i++) begin
            off = rand_bits(10);
            len = rand_bits(3);
            write_burst(0, off, len);
            write_burst(1, off, len);
            read_burst(0, off, len);
            read_burst(1, off, len);
            last_off = off;
            last_len = len;
        end
        finish_test("sram write and read-back", errs);

        errs = error_count;
        for (int i = 0; i < 6 && !timed_out; i++) begin
            len = rand_bits(3);
            write_burst(2, last_off, len);
            read_burst(2, last_off, len);
        end
        read_burst(0, last_off, last_len);
        read_burst(1, last_off, last_len);
        finish_test("unmapped accesses", errs);

        errs = error_count;
        for (int n = 0; n < 8 && !timed_out; n++) begin
            off = rand_bits(10);
            write_burst(n % 2, off, n);
            read_burst(n % 2, off, n);
        end
        finish_test("burst framing", errs);

        errs = error_count;
        stall_en = 1'b1;
        for (int i = 0; i < 16 && !timed_out; i++) begin
            region = rand_bits(2) % 3;
            off = rand_bits(10);
            len = rand_bits(3);
            write_burst(region, off, len);
            read_burst(region, off, len);
        end
        stall_en = 1'b0;
        finish_test("back-pressure", errs);

        $display("tests run %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end : main_proc

endmodule : tb_axi_subsys

/* test/axi_subsys_asserts.sv */
`timescale 1ns/100ps

module axi_subsys_asserts (
    input logic i_clk,
    input logic i_nrst,
    input types_amba_pkg::axi4_slave_in_type i_xmsti,
    input types_amba_pkg::axi4_slave_out_type i_xmsto
);

    import types_amba_pkg::*;

    // a stalled beat keeps its payload until r_ready
    r_hold_check: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_xmsto.r_valid && !i_xmsti.r_ready) |=> (i_xmsto.r_valid && $stable(i_xmsto.r_data)
            && $stable(i_xmsto.r_resp) && $stable(i_xmsto.r_last)))
        else $error("r channel changed while waiting for r_ready");

    b_hold_check: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_xmsto.b_valid && !i_xmsti.b_ready) |=> (i_xmsto.b_valid && $stable(i_xmsto.b_resp)))
        else $error("b channel changed while waiting for b_ready");

    r_last_check: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_xmsto.r_last |-> i_xmsto.r_valid)
        else $error("r_last high without r_valid");

    w_b_overlap_check: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(i_xmsto.w_ready && i_xmsto.b_valid))
        else $error("w_ready and b_valid high together");

endmodule : axi_subsys_asserts

bind axi_subsys_top axi_subsys_asserts protocol_chk (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .i_xmsti(i_xmsti),
    .i_xmsto(o_xmsto)
);

/* rtl/axi_subsys_top.sv */
`timescale 1ns/100ps

module axi_subsys_top (
    input logic i_clk,
    input logic i_nrst,
    input types_amba_pkg::axi4_slave_in_type i_xmsti,
    output types_amba_pkg::axi4_slave_out_type o_xmsto
);

    import types_amba_pkg::*;

    axi4_slave_in_type w_sram0_in;
    axi4_slave_in_type w_sram1_in;
    axi4_slave_in_type w_def_in;
    axi4_slave_out_type w_sram0_out;
    axi4_slave_out_type w_sram1_out;
    axi4_slave_out_type w_def_out;

    axi_bus_router router (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xmsti(i_xmsti),
        .o_xmsto(o_xmsto),
        .o_sram0_in(w_sram0_in),
        .i_sram0_out(w_sram0_out),
        .o_sram1_in(w_sram1_in),
        .i_sram1_out(w_sram1_out),
        .o_def_in(w_def_in),
        .i_def_out(w_def_out)
    );

    axi_sram_slave sram0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(w_sram0_in),
        .o_xslvo(w_sram0_out)
    );

    axi_sram_slave sram1 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(w_sram1_in),
        .o_xslvo(w_sram1_out)
    );

    axi_defslv defslv (  // catches every unmapped address
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_xslvi(w_def_in),
        .o_xslvo(w_def_out)
    );

endmodule : axi_subsys_top

/* xbar/axi_bus_router.sv */
`timescale 1ns/100ps
`include "amba_consts.svh"

module axi_bus_router (
    input logic i_clk,
    input logic i_nrst,
    input types_amba_pkg::axi4_slave_in_type i_xmsti,
    output types_amba_pkg::axi4_slave_out_type o_xmsto,
    output types_amba_pkg::axi4_slave_in_type o_sram0_in,
    input types_amba_pkg::axi4_slave_out_type i_sram0_out,
    output types_amba_pkg::axi4_slave_in_type o_sram1_in,
    input types_amba_pkg::axi4_slave_out_type i_sram1_out,
    output types_amba_pkg::axi4_slave_in_type o_def_in,
    input types_amba_pkg::axi4_slave_out_type i_def_out
);

    import types_amba_pkg::*;

    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_WRITE,
        ROUTE_READ
    } route_state_type;

    localparam logic [1:0] sel_sram0 = 2'd0;
    localparam logic [1:0] sel_sram1 = 2'd1;
    localparam logic [1:0] sel_def = 2'd2;

    route_state_type r_state, w_state_nxt;
    logic [1:0] r_sel, w_sel_nxt;  // slave owning the open transaction
    logic [1:0] w_aw_sel;
    logic [1:0] w_ar_sel;
    axi4_slave_out_type w_aw_tgt;
    axi4_slave_out_type w_ar_tgt;
    axi4_slave_out_type w_cur_tgt;

    function automatic logic [1:0] decode(input logic [`AXI_ADDR_W-1:0] addr);
        logic [1:0] sel;
        sel = sel_def;
        if ((addr >= `SRAM0_BASE) && (addr < (`SRAM0_BASE + `SRAM_SPAN))) begin
            sel = sel_sram0;
        end else if ((addr >= `SRAM1_BASE) && (addr < (`SRAM1_BASE + `SRAM_SPAN))) begin
            sel = sel_sram1;
        end
        return sel;
    endfunction

    function automatic axi4_slave_out_type pick(input logic [1:0] sel,
                                                input axi4_slave_out_type s0,
                                                input axi4_slave_out_type s1,
                                                input axi4_slave_out_type s2);
        axi4_slave_out_type res;
        case (sel)
            sel_sram0: res = s0;
            sel_sram1: res = s1;
            default: res = s2;
        endcase
        return res;
    endfunction

    assign w_aw_sel = decode(i_xmsti.aw_bits.addr);
    assign w_ar_sel = decode(i_xmsti.ar_bits.addr);
    assign w_aw_tgt = pick(w_aw_sel, i_sram0_out, i_sram1_out, i_def_out);
    assign w_ar_tgt = pick(w_ar_sel, i_sram0_out, i_sram1_out, i_def_out);
    assign w_cur_tgt = pick(r_sel, i_sram0_out, i_sram1_out, i_def_out);

    always_comb begin : route_proc
        axi4_slave_in_type v_quiet;
        axi4_slave_in_type v_fwd;
        axi4_slave_out_type v_out;
        logic [1:0] v_sel;

        w_state_nxt = r_state;
        w_sel_nxt = r_sel;
        v_quiet = i_xmsti;  // payload fans out, handshakes are gated
        v_quiet.aw_valid = 1'b0;
        v_quiet.w_valid = 1'b0;
        v_quiet.b_ready = 1'b0;
        v_quiet.ar_valid = 1'b0;
        v_quiet.r_ready = 1'b0;
        v_fwd = v_quiet;
        v_out = axi4_slave_out_none;
        v_sel = r_sel;

        case (r_state)
            ROUTE_IDLE: begin
                v_sel = i_xmsti.aw_valid ? w_aw_sel : w_ar_sel;
                v_fwd.aw_valid = i_xmsti.aw_valid;
                v_fwd.ar_valid = i_xmsti.ar_valid & ~i_xmsti.aw_valid;
                v_out.aw_ready = w_aw_tgt.aw_ready;
                v_out.ar_ready = w_ar_tgt.ar_ready & ~i_xmsti.aw_valid;
                if (i_xmsti.aw_valid && w_aw_tgt.aw_ready) begin
                    w_state_nxt = ROUTE_WRITE;
                    w_sel_nxt = w_aw_sel;
                end else if (i_xmsti.ar_valid && v_out.ar_ready) begin
                    w_state_nxt = ROUTE_READ;
                    w_sel_nxt = w_ar_sel;
                end
            end
            ROUTE_WRITE: begin
                v_fwd.w_valid = i_xmsti.w_valid;
                v_fwd.b_ready = i_xmsti.b_ready;
                v_out.w_ready = w_cur_tgt.w_ready;
                v_out.b_valid = w_cur_tgt.b_valid;
                v_out.b_resp = w_cur_tgt.b_resp;
                if (w_cur_tgt.b_valid && i_xmsti.b_ready) begin
                    w_state_nxt = ROUTE_IDLE;
                end
            end
            ROUTE_READ: begin
                v_fwd.r_ready = i_xmsti.r_ready;
                v_out.r_valid = w_cur_tgt.r_valid;
                v_out.r_data = w_cur_tgt.r_data;
                v_out.r_resp = w_cur_tgt.r_resp;
                v_out.r_last = w_cur_tgt.r_last;
                if (w_cur_tgt.r_valid && i_xmsti.r_ready && w_cur_tgt.r_last) begin
                    w_state_nxt = ROUTE_IDLE;
                end
            end
            default: w_state_nxt = ROUTE_IDLE;
        endcase

        o_xmsto = v_out;
        o_sram0_in = (v_sel == sel_sram0) ? v_fwd : v_quiet;
        o_sram1_in = (v_sel == sel_sram1) ? v_fwd : v_quiet;
        o_def_in = (v_sel == sel_def) ? v_fwd : v_quiet;
    end : route_proc

    always_ff @(posedge i_clk or negedge i_nrst) begin : reg_proc
        if (!i_nrst) begin
            r_state <= ROUTE_IDLE;
            r_sel <= sel_def;
        end else begin
            r_state <= w_state_nxt;
            r_sel <= w_sel_nxt;
        end
    end : reg_proc

endmodule : axi_bus_router

/* rtl/axi_sram_slave.sv */
`timescale 1ns/100ps
`include "amba_consts.svh"

module axi_sram_slave (
    input logic i_clk,
    input logic i_nrst,
    input types_amba_pkg::axi4_slave_in_type i_xslvi,
    output types_amba_pkg::axi4_slave_out_type o_xslvo
);

    import types_amba_pkg::*;

    localparam int word_bits = $clog2(`SRAM_WORDS);

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_R,
        SRAM_W,
        SRAM_B
    } sram_state_type;

    logic [`AXI_DATA_W-1:0] mem [0:`SRAM_WORDS-1];

    sram_state_type r_state, w_state_nxt;
    logic [7:0] r_cnt, w_cnt_nxt;
    logic [word_bits-1:0] r_addr, w_addr_nxt;  // next word to access
    logic [`AXI_DATA_W-1:0] r_rdata;
    logic w_mem_we;
    logic w_rd_en;
    logic [word_bits-1:0] w_rd_addr;
    logic [word_bits-1:0] w_aw_word;
    logic [word_bits-1:0] w_ar_word;

    // byte address to word index, wraps inside the array
    assign w_aw_word = i_xslvi.aw_bits.addr[word_bits+1:2];
    assign w_ar_word = i_xslvi.ar_bits.addr[word_bits+1:2];

    always_comb begin : main_proc
        axi4_slave_out_type v_out;

        w_state_nxt = r_state;
        w_cnt_nxt = r_cnt;
        w_addr_nxt = r_addr;
        w_mem_we = 1'b0;
        w_rd_en = 1'b0;
        w_rd_addr = r_addr;
        v_out = axi4_slave_out_none;

        case (r_state)
            SRAM_IDLE: begin
                v_out.aw_ready = 1'b1;
                v_out.ar_ready = ~i_xslvi.aw_valid;
                if (i_xslvi.aw_valid) begin
                    w_state_nxt = SRAM_W;
                    w_cnt_nxt = i_xslvi.aw_bits.len;
                    w_addr_nxt = w_aw_word;
                end else if (i_xslvi.ar_valid) begin
                    w_state_nxt = SRAM_R;
                    w_cnt_nxt = i_xslvi.ar_bits.len;
                    w_rd_en = 1'b1;  // first beat fetched with the handshake
                    w_rd_addr = w_ar_word;
                    w_addr_nxt = w_ar_word + 1'b1;
                end
            end
            SRAM_R: begin
                v_out.r_valid = 1'b1;
                v_out.r_data = r_rdata;
                v_out.r_last = (r_cnt == 8'd0);
                if (i_xslvi.r_ready) begin
                    if (r_cnt == 8'd0) begin
                        w_state_nxt = SRAM_IDLE;
                    end else begin
                        w_rd_en = 1'b1;
                        w_addr_nxt = r_addr + 1'b1;
                        w_cnt_nxt = r_cnt - 8'd1;
                    end
                end
            end
            SRAM_W: begin
                v_out.w_ready = 1'b1;
                if (i_xslvi.w_valid) begin
                    w_mem_we = 1'b1;
                    w_addr_nxt = r_addr + 1'b1;
                    if (r_cnt == 8'd0) begin
                        w_state_nxt = SRAM_B;
                    end else begin
                        w_cnt_nxt = r_cnt - 8'd1;
                    end
                end
            end
            SRAM_B: begin
                v_out.b_valid = 1'b1;
                if (i_xslvi.b_ready) begin
                    w_state_nxt = SRAM_IDLE;
                end
            end
            default: w_state_nxt = SRAM_IDLE;
        endcase

        o_xslvo = v_out;
    end : main_proc

    always_ff @(posedge i_clk) begin : mem_proc
        if (w_mem_we) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (i_xslvi.w_strb[i]) begin
                    mem[r_addr][8*i +: 8] <= i_xslvi.w_data[8*i +: 8];
                end
            end
        end
        if (w_rd_en) begin
            r_rdata <= mem[w_rd_addr];
        end
    end : mem_proc

    always_ff @(posedge i_clk or negedge i_nrst) begin : reg_proc
        if (!i_nrst) begin
            r_state <= SRAM_IDLE;
            r_cnt <= '0;
            r_addr <= '0;
        end else begin
            r_state <= w_state_nxt;
            r_cnt <= w_cnt_nxt;
            r_addr <= w_addr_nxt;
        end
    end : reg_proc

endmodule : axi_sram_slave

/* rtl/axi_defslv.sv */
`timescale 1ns/100ps

module axi_defslv (
    input logic i_clk,
    input logic i_nrst,
    input types_amba_pkg::axi4_slave_in_type i_xslvi,
    output types_amba_pkg::axi4_slave_out_type o_xslvo
);

    import types_amba_pkg::*;

    typedef enum logic [1:0] {
        DEFSLV_IDLE,
        DEFSLV_R,
        DEFSLV_W,
        DEFSLV_B
    } defslv_state_type;

    defslv_state_type r_state, w_state_nxt;
    logic [7:0] r_cnt, w_cnt_nxt;  // beats left minus one

    always_comb begin : main_proc
        axi4_slave_out_type v_out;

        w_state_nxt = r_state;
        w_cnt_nxt = r_cnt;
        v_out = axi4_slave_out_none;
        v_out.b_resp = AXI_RESP_DECERR;
        v_out.r_resp = AXI_RESP_DECERR;

        case (r_state)
            DEFSLV_IDLE: begin
                v_out.aw_ready = 1'b1;
                v_out.ar_ready = ~i_xslvi.aw_valid;  // write wins
                if (i_xslvi.aw_valid) begin
                    w_state_nxt = DEFSLV_W;
                    w_cnt_nxt = i_xslvi.aw_bits.len;
                end else if (i_xslvi.ar_valid) begin
                    w_state_nxt = DEFSLV_R;
                    w_cnt_nxt = i_xslvi.ar_bits.len;
                end
            end
            DEFSLV_R: begin
                v_out.r_valid = 1'b1;
                v_out.r_data = '1;
                v_out.r_last = (r_cnt == 8'd0);
                if (i_xslvi.r_ready) begin
                    if (r_cnt == 8'd0) begin
                        w_state_nxt = DEFSLV_IDLE;
                    end else begin
                        w_cnt_nxt = r_cnt - 8'd1;
                    end
                end
            end
            DEFSLV_W: begin
                v_out.w_ready = 1'b1;
                if (i_xslvi.w_valid) begin  // w_last not checked, count decides
                    if (r_cnt == 8'd0) begin
                        w_state_nxt = DEFSLV_B;
                    end else begin
                        w_cnt_nxt = r_cnt - 8'd1;
                    end
                end
            end
            DEFSLV_B: begin
                v_out.b_valid = 1'b1;
                if (i_xslvi.b_ready) begin
                    w_state_nxt = DEFSLV_IDLE;
                end
            end
            default: w_state_nxt = DEFSLV_IDLE;
        endcase

        o_xslvo = v_out;
    end : main_proc

    always_ff @(posedge i_clk or negedge i_nrst) begin : reg_proc
        if (!i_nrst) begin
            r_state <= DEFSLV_IDLE;
            r_cnt <= '0;
        end else begin
            r_state <= w_state_nxt;
            r_cnt <= w_cnt_nxt;
        end
    end : reg_proc

endmodule : axi_defslv

/* common/types_amba_pkg.sv */
package types_amba_pkg;

`include "amba_consts.svh"

typedef enum logic [1:0] {
    AXI_RESP_OKAY = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
} axi_resp_type;

// aw/ar payload
typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0] len;  // beats minus one
} axi4_metadata_type;

// master to slave
typedef struct packed {
    logic aw_valid;
    axi4_metadata_type aw_bits;
    logic w_valid;
    logic [`AXI_DATA_W-1:0] w_data;
    logic [`AXI_STRB_W-1:0] w_strb;
    logic w_last;
    logic b_ready;
    logic ar_valid;
    axi4_metadata_type ar_bits;
    logic r_ready;
} axi4_slave_in_type;

// slave to master
typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic b_valid;
    axi_resp_type b_resp;
    logic ar_ready;
    logic r_valid;
    logic [`AXI_DATA_W-1:0] r_data;
    axi_resp_type r_resp;
    logic r_last;
} axi4_slave_out_type;

localparam axi4_slave_out_type axi4_slave_out_none = '{
    aw_ready: 1'b0,
    w_ready: 1'b0,
    b_valid: 1'b0,
    b_resp: AXI_RESP_OKAY,
    ar_ready: 1'b0,
    r_valid: 1'b0,
    r_data: '0,
    r_resp: AXI_RESP_OKAY,
    r_last: 1'b0
};

endpackage : types_amba_pkg

/* common/amba_consts.svh */
`ifndef AMBA_CONSTS_SVH
`define AMBA_CONSTS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_LEN_W 8

// memory map, one 4 KB window per sram
`define SRAM0_BASE 32'h0000_0000
`define SRAM1_BASE 32'h0000_1000
`define SRAM_SPAN 32'h0000_1000

// words per sram instance
`define SRAM_WORDS 1024

`endif
